//--- rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Width of an architectural register index
  localparam int REG_ADDR_W = 5;
  // Widths of the PC-mux mode and the EX operand source
  localparam int PC_SEL_W = 2;
  localparam int FWD_SEL_W = 2;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // PC-mux mode reported by the EX stage
  typedef enum logic [PC_SEL_W-1:0] {
    PC_SEL_SEQ       = 2'd0,
    PC_SEL_PREDICTED = 2'd1,
    PC_SEL_REDIRECT  = 2'd2,
    PC_SEL_RESERVED  = 2'd3
  } pc_sel_e;

  // BRAM returns load data a cycle late, SRAM has it in MEM
  typedef enum logic {
    MEM_TYPE_BRAM = 1'b0,
    MEM_TYPE_SRAM = 1'b1
  } mem_type_e;

  // Operand source for the instruction in EX
  typedef enum logic [FWD_SEL_W-1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_e;

  // True when a producer writing rd feeds a consumer reading rs
  // Register 0 is hardwired and never links two instructions
  function automatic logic reg_match(reg_addr_t rd, logic we, reg_addr_t rs, logic used);
    return we && used && (rd != '0) && (rd == rs);
  endfunction

endpackage

//--- rv_stage_if.sv
`timescale 1ns/1ns

interface stage_if;
  import rv_pipe_pkg::*;

  // Register-level descriptor of the instruction held in one stage
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs1_used;
  logic      rs2_used;
  reg_addr_t rd;
  logic      reg_write;
  logic      is_load;
  logic      is_csr;
  logic      is_multi;

  // The stage register owns the descriptor
  modport source(output rs1, rs2, rs1_used, rs2_used, rd, reg_write, is_load, is_csr, is_multi);

  // Hazard and forwarding logic only look at it
  modport sink(input rs1, rs2, rs1_used, rs2_used, rd, reg_write, is_load, is_csr, is_multi);

endinterface

//--- rv_hazard.sv
`timescale 1ns/1ns

module rv_hazard #(
  parameter int FWD = 1,
  parameter int FWD_REGFILE = 0,
  parameter rv_pipe_pkg::mem_type_e MEM_TYPE = rv_pipe_pkg::MEM_TYPE_BRAM
) (
  // Sources read by the instruction sitting in ID
  input  rv_pipe_pkg::reg_addr_t rs1_id,
  input  rv_pipe_pkg::reg_addr_t rs2_id,
  input  logic                   rs1_used_id,
  input  logic                   rs2_used_id,

  // Descriptors of the instructions further down the pipe
  stage_if.sink                  ex_stage,
  stage_if.sink                  mem_stage,
  stage_if.sink                  wb_stage,

  input  logic                   op_active_ex,
  input  rv_pipe_pkg::pc_sel_e   pc_sel,
  input  logic                   mispredicted_ex,
  // Tells whether a predicted PC this cycle came from the BTB in IF
  input  logic                   btb_pred_taken,

  output logic                   pc_stall,
  output logic                   if_id_stall,
  output logic                   if_id_flush,
  output logic                   id_ex_stall,
  output logic                   id_ex_flush,
  output logic                   ex_mem_stall,
  output logic                   mem_wb_stall
);
  import rv_pipe_pkg::*;

  logic ex_hit;
  logic wb_hit;
  logic data_hazard;
  logic pc_redirect;
  logic pc_predicted;

  // ID reads a register that the instruction in EX is about to write
  assign ex_hit = reg_match(ex_stage.rd, ex_stage.reg_write, rs1_id, rs1_used_id) ||
                  reg_match(ex_stage.rd, ex_stage.reg_write, rs2_id, rs2_used_id);

  // A register file without write-through cannot serve a WB result in ID
  // so that case has to be treated as a hazard
  if (FWD_REGFILE == 0) begin : g_wb_check
    assign wb_hit = reg_match(wb_stage.rd, wb_stage.reg_write, rs1_id, rs1_used_id) ||
                    reg_match(wb_stage.rd, wb_stage.reg_write, rs2_id, rs2_used_id);
  end else begin : g_wb_bypass
    assign wb_hit = 1'b0;
  end

  if (FWD == 0) begin : g_stall_all
    logic mem_hit;

    // Without a bypass network every RAW dependency waits for write back
    assign mem_hit = reg_match(mem_stage.rd, mem_stage.reg_write, rs1_id, rs1_used_id) ||
                     reg_match(mem_stage.rd, mem_stage.reg_write, rs2_id, rs2_used_id);
    assign data_hazard = ex_hit || mem_hit || wb_hit;
  end else begin : g_stall_late
    logic ex_late;

    // Results that only exist after MEM cannot reach the next EX in time
    // CSR reads always land in WB, BRAM loads also come back too late
    if (MEM_TYPE == MEM_TYPE_BRAM) begin : g_bram
      assign ex_late = ex_stage.is_load || ex_stage.is_csr;
    end else begin : g_sram
      assign ex_late = ex_stage.is_csr;
    end

    assign data_hazard = (ex_late && ex_hit) || wb_hit;
  end

  // A data hazard freezes the front end, a multi-cycle op freezes everything
  assign pc_stall     = data_hazard || op_active_ex;
  assign if_id_stall  = data_hazard || op_active_ex;
  assign id_ex_stall  = op_active_ex;
  assign ex_mem_stall = op_active_ex;
  assign mem_wb_stall = op_active_ex;

  assign pc_redirect  = (pc_sel == PC_SEL_REDIRECT);
  assign pc_predicted = (pc_sel == PC_SEL_PREDICTED);

  // The dependent instruction stays in ID and a bubble goes to EX
  // During a multi-cycle op EX is held instead of being flushed
  assign id_ex_flush = (data_hazard && !op_active_ex) || pc_redirect || mispredicted_ex;

  // A static prediction in ID makes the fetched sequential word wrong
  // A BTB hit was already steered in IF and keeps its instruction
  // While stalling the predicting branch has not left ID yet
  assign if_id_flush = pc_redirect || mispredicted_ex ||
                       (pc_predicted && !btb_pred_taken && !data_hazard && !op_active_ex);

  always_comb begin
    // Outside of control redirects ID/EX is either held or bubbled, not both
    if (!pc_redirect && !mispredicted_ex) begin
      assert (!(id_ex_stall && id_ex_flush))
        else $error("id_ex_stall and id_ex_flush both high without redirect");
    end
    // The countdown only runs for a multi-cycle op that is still in EX
    assert (!op_active_ex || (pc_stall && ex_stage.is_multi))
      else $error("op_active_ex without a stalled multi-cycle op in EX");
  end

endmodule

//--- rv_forward.sv
`timescale 1ns/1ns

module rv_forward #(
  parameter int FWD = 1
) (
  // Consumer in EX, producers in MEM and WB
  stage_if.sink                   ex_stage,
  stage_if.sink                   mem_stage,
  stage_if.sink                   wb_stage,

  output rv_pipe_pkg::fwd_sel_e   fwd_rs1_ex,
  output rv_pipe_pkg::fwd_sel_e   fwd_rs2_ex
);
  import rv_pipe_pkg::*;

  if (FWD != 0) begin : g_forward
    logic mem_rs1;
    logic mem_rs2;
    logic wb_rs1;
    logic wb_rs2;

    assign mem_rs1 = reg_match(mem_stage.rd, mem_stage.reg_write, ex_stage.rs1, ex_stage.rs1_used);
    assign mem_rs2 = reg_match(mem_stage.rd, mem_stage.reg_write, ex_stage.rs2, ex_stage.rs2_used);
    assign wb_rs1  = reg_match(wb_stage.rd, wb_stage.reg_write, ex_stage.rs1, ex_stage.rs1_used);
    assign wb_rs2  = reg_match(wb_stage.rd, wb_stage.reg_write, ex_stage.rs2, ex_stage.rs2_used);

    // MEM holds the younger producer, so its value wins over WB
    always_comb begin
      fwd_rs1_ex = FWD_NONE;
      if (mem_rs1) begin
        fwd_rs1_ex = FWD_MEM;
      end else if (wb_rs1) begin
        fwd_rs1_ex = FWD_WB;
      end

      fwd_rs2_ex = FWD_NONE;
      if (mem_rs2) begin
        fwd_rs2_ex = FWD_MEM;
      end else if (wb_rs2) begin
        fwd_rs2_ex = FWD_WB;
      end
    end
  end else begin : g_no_forward
    // The hazard unit already stalls until the register file is current
    assign fwd_rs1_ex = FWD_NONE;
    assign fwd_rs2_ex = FWD_NONE;
  end

  always_comb begin
    // A bypass only ever taps a stage that really writes a register
    assert (((fwd_rs1_ex != FWD_MEM) && (fwd_rs2_ex != FWD_MEM)) || mem_stage.reg_write)
      else $error("MEM forward selected while MEM does not write");
    assert (((fwd_rs1_ex != FWD_WB) && (fwd_rs2_ex != FWD_WB)) || wb_stage.reg_write)
      else $error("WB forward selected while WB does not write");
  end

endmodule

//--- rv_stage_regs.sv
`timescale 1ns/1ns

module rv_stage_regs #(
  parameter int MULTI_LATENCY = 3
) (
  input  logic                   clk,
  input  logic                   reset,

  // Decoded descriptor of the instruction in ID
  input  rv_pipe_pkg::reg_addr_t rs1_id,
  input  rv_pipe_pkg::reg_addr_t rs2_id,
  input  logic                   rs1_used_id,
  input  logic                   rs2_used_id,
  input  rv_pipe_pkg::reg_addr_t rd_id,
  input  logic                   reg_write_id,
  input  logic                   is_load_id,
  input  logic                   is_csr_id,
  input  logic                   is_multi_id,

  input  logic                   id_ex_stall,
  input  logic                   id_ex_flush,
  input  logic                   ex_mem_stall,
  input  logic                   mem_wb_stall,

  stage_if.source                ex_stage,
  stage_if.source                mem_stage,
  stage_if.source                wb_stage,

  output logic                   op_active_ex
);
  // Wide enough to hold MULTI_LATENCY - 1 for every legal latency
  localparam int CNT_W = $clog2(MULTI_LATENCY);

  logic [CNT_W-1:0] multi_cnt;

  // Register numbers move down the pipe under the same stall levels as the flags
  always_ff @(posedge clk) begin
    if (!id_ex_stall) begin
      ex_stage.rs1 <= rs1_id;
      ex_stage.rs2 <= rs2_id;
      ex_stage.rd  <= rd_id;
    end
    if (!ex_mem_stall) begin
      mem_stage.rs1 <= ex_stage.rs1;
      mem_stage.rs2 <= ex_stage.rs2;
      mem_stage.rd  <= ex_stage.rd;
    end
    if (!mem_wb_stall) begin
      wb_stage.rs1 <= mem_stage.rs1;
      wb_stage.rs2 <= mem_stage.rs2;
      wb_stage.rd  <= mem_stage.rd;
    end
  end

  // ID/EX flags
  // A flush overrides the hold
  always_ff @(posedge clk) begin
    if (reset || id_ex_flush) begin
      ex_stage.rs1_used  <= 1'b0;
      ex_stage.rs2_used  <= 1'b0;
      ex_stage.reg_write <= 1'b0;
      ex_stage.is_load   <= 1'b0;
      ex_stage.is_csr    <= 1'b0;
      ex_stage.is_multi  <= 1'b0;
    end else if (!id_ex_stall) begin
      ex_stage.rs1_used  <= rs1_used_id;
      ex_stage.rs2_used  <= rs2_used_id;
      ex_stage.reg_write <= reg_write_id;
      ex_stage.is_load   <= is_load_id;
      ex_stage.is_csr    <= is_csr_id;
      ex_stage.is_multi  <= is_multi_id;
    end
  end

  // EX/MEM flags follow EX whenever the back end is not frozen
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_stage.rs1_used  <= 1'b0;
      mem_stage.rs2_used  <= 1'b0;
      mem_stage.reg_write <= 1'b0;
      mem_stage.is_load   <= 1'b0;
      mem_stage.is_csr    <= 1'b0;
      mem_stage.is_multi  <= 1'b0;
    end else if (!ex_mem_stall) begin
      mem_stage.rs1_used  <= ex_stage.rs1_used;
      mem_stage.rs2_used  <= ex_stage.rs2_used;
      mem_stage.reg_write <= ex_stage.reg_write;
      mem_stage.is_load   <= ex_stage.is_load;
      mem_stage.is_csr    <= ex_stage.is_csr;
      mem_stage.is_multi  <= ex_stage.is_multi;
    end
  end

  // MEM/WB flags
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_stage.rs1_used  <= 1'b0;
      wb_stage.rs2_used  <= 1'b0;
      wb_stage.reg_write <= 1'b0;
      wb_stage.is_load   <= 1'b0;
      wb_stage.is_csr    <= 1'b0;
      wb_stage.is_multi  <= 1'b0;
    end else if (!mem_wb_stall) begin
      wb_stage.rs1_used  <= mem_stage.rs1_used;
      wb_stage.rs2_used  <= mem_stage.rs2_used;
      wb_stage.reg_write <= mem_stage.reg_write;
      wb_stage.is_load   <= mem_stage.is_load;
      wb_stage.is_csr    <= mem_stage.is_csr;
      wb_stage.is_multi  <= mem_stage.is_multi;
    end
  end

  // A multi-cycle op loads the count as it enters EX and holds EX until zero
  // Together with the entry cycle that gives MULTI_LATENCY cycles in EX
  // A flush cancels the op in EX and with it the remaining count
  always_ff @(posedge clk) begin
    if (reset || id_ex_flush) begin
      multi_cnt <= '0;
    end else if (multi_cnt != '0) begin
      multi_cnt <= multi_cnt - 1'b1;
    end else if (!id_ex_stall && is_multi_id) begin
      multi_cnt <= CNT_W'(MULTI_LATENCY - 1);
    end
  end

  assign op_active_ex = (multi_cnt != '0);

  // The count must never start above the configured latency
  assert property (@(posedge clk) disable iff (reset) multi_cnt <= CNT_W'(MULTI_LATENCY - 1))
    else $error("multi-cycle count 0x%0h above latency", multi_cnt);

endmodule

//--- rv_pipe_ctl.sv
`timescale 1ns/1ns

module rv_pipe_ctl #(
  parameter int FWD = 1,
  parameter int FWD_REGFILE = 0,
  parameter rv_pipe_pkg::mem_type_e MEM_TYPE = rv_pipe_pkg::MEM_TYPE_BRAM,
  parameter int MULTI_LATENCY = 3
) (
  input  logic                    clk,
  input  logic                    reset,

  // Instruction descriptor in ID
  input  rv_pipe_pkg::reg_addr_t  rs1_id,
  input  rv_pipe_pkg::reg_addr_t  rs2_id,
  input  logic                    rs1_used_id,
  input  logic                    rs2_used_id,
  input  rv_pipe_pkg::reg_addr_t  rd_id,
  input  logic                    reg_write_id,
  input  logic                    is_load_id,
  input  logic                    is_csr_id,
  input  logic                    is_multi_id,

  // Branch resolution and prediction status
  input  rv_pipe_pkg::pc_sel_e    pc_sel,
  input  logic                    mispredicted_ex,
  input  logic                    btb_pred_taken,

  output logic                    pc_stall,
  output logic                    if_id_stall,
  output logic                    if_id_flush,
  output logic                    id_ex_stall,
  output logic                    id_ex_flush,
  output logic                    ex_mem_stall,
  output logic                    mem_wb_stall,
  output rv_pipe_pkg::fwd_sel_e   fwd_rs1_ex,
  output rv_pipe_pkg::fwd_sel_e   fwd_rs2_ex,
  output logic                    op_active_ex
);

  stage_if ex_stage ();
  stage_if mem_stage ();
  stage_if wb_stage ();

  rv_stage_regs #(
    .MULTI_LATENCY (MULTI_LATENCY)
  ) stage_regs (
    .clk          (clk),
    .reset        (reset),
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_used_id  (rs1_used_id),
    .rs2_used_id  (rs2_used_id),
    .rd_id        (rd_id),
    .reg_write_id (reg_write_id),
    .is_load_id   (is_load_id),
    .is_csr_id    (is_csr_id),
    .is_multi_id  (is_multi_id),
    .id_ex_stall  (id_ex_stall),
    .id_ex_flush  (id_ex_flush),
    .ex_mem_stall (ex_mem_stall),
    .mem_wb_stall (mem_wb_stall),
    .ex_stage     (ex_stage.source),
    .mem_stage    (mem_stage.source),
    .wb_stage     (wb_stage.source),
    .op_active_ex (op_active_ex)
  );

  rv_hazard #(
    .FWD         (FWD),
    .FWD_REGFILE (FWD_REGFILE),
    .MEM_TYPE    (MEM_TYPE)
  ) hazard (
    .rs1_id          (rs1_id),
    .rs2_id          (rs2_id),
    .rs1_used_id     (rs1_used_id),
    .rs2_used_id     (rs2_used_id),
    .ex_stage        (ex_stage.sink),
    .mem_stage       (mem_stage.sink),
    .wb_stage        (wb_stage.sink),
    .op_active_ex    (op_active_ex),
    .pc_sel          (pc_sel),
    .mispredicted_ex (mispredicted_ex),
    .btb_pred_taken  (btb_pred_taken),
    .pc_stall        (pc_stall),
    .if_id_stall     (if_id_stall),
    .if_id_flush     (if_id_flush),
    .id_ex_stall     (id_ex_stall),
    .id_ex_flush     (id_ex_flush),
    .ex_mem_stall    (ex_mem_stall),
    .mem_wb_stall    (mem_wb_stall)
  );

  rv_forward #(
    .FWD (FWD)
  ) forward (
    .ex_stage   (ex_stage.sink),
    .mem_stage  (mem_stage.sink),
    .wb_stage   (wb_stage.sink),
    .fwd_rs1_ex (fwd_rs1_ex),
    .fwd_rs2_ex (fwd_rs2_ex)
  );

endmodule

//--- tb_rv_pipe_ctl.sv
`timescale 1ns/1ns

module tb_rv_pipe_ctl #(
  parameter int FWD = 1,
  parameter int FWD_REGFILE = 0,
  parameter int MEM_TYPE = 0,
  parameter int MULTI_LATENCY = 3
);
  import rv_pipe_pkg::*;

  // Cycle budget of each phase
  // The run limit adds a margin on top of all phases
  localparam int RESET_CYCLES = 3;
  localparam int DATA_CYCLES = 400;
  localparam int MULTI_CYCLES = 200;
  localparam int CTRL_CYCLES = 400;
  localparam int MIX_CYCLES = 600;
  localparam int CYCLE_LIMIT = RESET_CYCLES + 1 + DATA_CYCLES + MULTI_CYCLES + CTRL_CYCLES +
                               MIX_CYCLES + 100;

  localparam int MODE_DATA = 0;
  localparam int MODE_MULTI = 1;
  localparam int MODE_CTRL = 2;
  localparam int MODE_MIX = 3;

  localparam mem_type_e MEM_KIND = mem_type_e'(MEM_TYPE);

  // Register-level view of one pipeline stage as the model sees it
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      rs1_used;
    logic      rs2_used;
    reg_addr_t rd;
    logic      reg_write;
    logic      is_load;
    logic      is_csr;
    logic      is_multi;
  } desc_t;

  logic      clk;
  logic      reset;
  reg_addr_t rs1_id;
  reg_addr_t rs2_id;
  logic      rs1_used_id;
  logic      rs2_used_id;
  reg_addr_t rd_id;
  logic      reg_write_id;
  logic      is_load_id;
  logic      is_csr_id;
  logic      is_multi_id;
  pc_sel_e   pc_sel;
  logic      mispredicted_ex;
  logic      btb_pred_taken;
  logic      pc_stall;
  logic      if_id_stall;
  logic      if_id_flush;
  logic      id_ex_stall;
  logic      id_ex_flush;
  logic      ex_mem_stall;
  logic      mem_wb_stall;
  fwd_sel_e  fwd_rs1_ex;
  fwd_sel_e  fwd_rs2_ex;
  logic      op_active_ex;

  // Model state and its predicted outputs
  desc_t    m_ex;
  desc_t    m_mem;
  desc_t    m_wb;
  int       m_cnt;
  logic     exp_front_stall;
  logic     exp_back_stall;
  logic     exp_if_id_flush;
  logic     exp_id_ex_flush;
  fwd_sel_e exp_fwd1;
  fwd_sel_e exp_fwd2;

  // DUT control levels seen in the cycle before the next edge
  logic s_if_id_stall;
  logic s_id_ex_stall;
  logic s_id_ex_flush;
  logic s_ex_mem_stall;
  logic s_mem_wb_stall;

  int errors = 0;
  int cycle_count = 0;
  int active_run = 0;
  int multi_runs = 0;

  rv_pipe_ctl #(
    .FWD           (FWD),
    .FWD_REGFILE   (FWD_REGFILE),
    .MEM_TYPE      (MEM_KIND),
    .MULTI_LATENCY (MULTI_LATENCY)
  ) UUT (
    .clk             (clk),
    .reset           (reset),
    .rs1_id          (rs1_id),
    .rs2_id          (rs2_id),
    .rs1_used_id     (rs1_used_id),
    .rs2_used_id     (rs2_used_id),
    .rd_id           (rd_id),
    .reg_write_id    (reg_write_id),
    .is_load_id      (is_load_id),
    .is_csr_id       (is_csr_id),
    .is_multi_id     (is_multi_id),
    .pc_sel          (pc_sel),
    .mispredicted_ex (mispredicted_ex),
    .btb_pred_taken  (btb_pred_taken),
    .pc_stall        (pc_stall),
    .if_id_stall     (if_id_stall),
    .if_id_flush     (if_id_flush),
    .id_ex_stall     (id_ex_stall),
    .id_ex_flush     (id_ex_flush),
    .ex_mem_stall    (ex_mem_stall),
    .mem_wb_stall    (mem_wb_stall),
    .fwd_rs1_ex      (fwd_rs1_ex),
    .fwd_rs2_ex      (fwd_rs2_ex),
    .op_active_ex    (op_active_ex)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Hard stop in case a phase never completes
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after reaching the cycle limit of %0d", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  // A producer feeds a consumer source only through a real nonzero destination
  function automatic logic reads_result(desc_t prod, reg_addr_t rs, logic used);
    return prod.reg_write && used && (prod.rd != 5'd0) && (prod.rd == rs);
  endfunction

  // The younger producer in MEM takes priority over WB
  function automatic fwd_sel_e pick_source(reg_addr_t rs, logic used);
    if (FWD == 0) begin
      return FWD_NONE;
    end
    if (reads_result(m_mem, rs, used)) begin
      return FWD_MEM;
    end
    if (reads_result(m_wb, rs, used)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  task automatic predict();
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;
    logic late;
    logic hazard;
    logic active;
    logic redirect;
    ex_hit = reads_result(m_ex, rs1_id, rs1_used_id) || reads_result(m_ex, rs2_id, rs2_used_id);
    mem_hit = reads_result(m_mem, rs1_id, rs1_used_id) ||
              reads_result(m_mem, rs2_id, rs2_used_id);
    wb_hit = (FWD_REGFILE == 0) && (reads_result(m_wb, rs1_id, rs1_used_id) ||
                                    reads_result(m_wb, rs2_id, rs2_used_id));
    // With bypassing only late EX results and an unbypassed WB stall the front end
    if (FWD == 0) begin
      hazard = ex_hit || mem_hit || wb_hit;
    end else begin
      late = m_ex.is_csr || (m_ex.is_load && (MEM_KIND == MEM_TYPE_BRAM));
      hazard = (late && ex_hit) || wb_hit;
    end
    active = (m_cnt != 0);
    redirect = (pc_sel == PC_SEL_REDIRECT) || mispredicted_ex;
    exp_front_stall = hazard || active;
    exp_back_stall = active;
    exp_id_ex_flush = (hazard && !active) || redirect;
    exp_if_id_flush = redirect ||
                      ((pc_sel == PC_SEL_PREDICTED) && !btb_pred_taken && !hazard && !active);
    exp_fwd1 = pick_source(m_ex.rs1, m_ex.rs1_used);
    exp_fwd2 = pick_source(m_ex.rs2, m_ex.rs2_used);
  endtask

  task automatic expect_val(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%0h exp 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_outputs();
    expect_val("pc_stall", pc_stall, exp_front_stall);
    expect_val("if_id_stall", if_id_stall, exp_front_stall);
    expect_val("id_ex_stall", id_ex_stall, exp_back_stall);
    expect_val("ex_mem_stall", ex_mem_stall, exp_back_stall);
    expect_val("mem_wb_stall", mem_wb_stall, exp_back_stall);
    expect_val("op_active_ex", op_active_ex, exp_back_stall);
    expect_val("if_id_flush", if_id_flush, exp_if_id_flush);
    expect_val("id_ex_flush", id_ex_flush, exp_id_ex_flush);
    expect_val("fwd_rs1_ex", fwd_rs1_ex, exp_fwd1);
    expect_val("fwd_rs2_ex", fwd_rs2_ex, exp_fwd2);
  endtask

  // Register updates follow the stall and flush levels the DUT produced
  task automatic advance_model();
    desc_t id_desc;
    id_desc = '{rs1_id, rs2_id, rs1_used_id, rs2_used_id, rd_id,
                reg_write_id, is_load_id, is_csr_id, is_multi_id};
    if (s_id_ex_flush) begin
      m_cnt = 0;
    end else if (m_cnt != 0) begin
      m_cnt--;
    end else if (!s_id_ex_stall && is_multi_id) begin
      m_cnt = MULTI_LATENCY - 1;
    end
    if (!s_mem_wb_stall) begin
      m_wb = m_mem;
    end
    if (!s_ex_mem_stall) begin
      m_mem = m_ex;
    end
    if (s_id_ex_flush) begin
      m_ex = '0;
    end else if (!s_id_ex_stall) begin
      m_ex = id_desc;
    end
  endtask

  task automatic drive_inputs(int mode);
    // ID holds its instruction while the front end is stalled
    if (!s_if_id_stall) begin
      rs1_id <= reg_addr_t'($urandom_range(7));
      rs2_id <= reg_addr_t'($urandom_range(7));
      rd_id <= reg_addr_t'($urandom_range(7));
      rs1_used_id <= 1'($urandom_range(1));
      rs2_used_id <= 1'($urandom_range(1));
      reg_write_id <= 1'($urandom_range(1));
      is_load_id <= (mode != MODE_MULTI) && ($urandom_range(3) == 0);
      is_csr_id <= (mode != MODE_MULTI) && ($urandom_range(3) == 0);
      is_multi_id <= (mode == MODE_MULTI) || ((mode == MODE_MIX) && ($urandom_range(7) == 0));
    end
    if ((mode == MODE_CTRL) || (mode == MODE_MIX)) begin
      pc_sel <= pc_sel_e'($urandom_range(3));
      mispredicted_ex <= ($urandom_range(3) == 0);
      btb_pred_taken <= 1'($urandom_range(1));
    end else begin
      pc_sel <= PC_SEL_SEQ;
      mispredicted_ex <= 1'b0;
      btb_pred_taken <= 1'b0;
    end
  endtask

  // A multi-cycle op holds EX for MULTI_LATENCY - 1 cycles after it enters
  task automatic track_multi();
    if (op_active_ex) begin
      active_run++;
      if (!(pc_stall && if_id_stall && id_ex_stall && ex_mem_stall && mem_wb_stall)) begin
        errors++;
        $display("Not every stall is high while a multi-cycle op holds EX at %0t", $time);
      end
      expect_val("id_ex_flush", id_ex_flush, 1'b0);
    end else if (active_run != 0) begin
      expect_val("op_active_ex run length", active_run, MULTI_LATENCY - 1);
      multi_runs++;
      active_run = 0;
    end
  endtask

  task automatic run_phase(int num, string name, int mode, int cycles);
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      advance_model();
      drive_inputs(mode);
      @(negedge clk);
      predict();
      check_outputs();
      if (mode == MODE_MULTI) begin
        track_multi();
      end
      s_if_id_stall = if_id_stall;
      s_id_ex_stall = id_ex_stall;
      s_id_ex_flush = id_ex_flush;
      s_ex_mem_stall = ex_mem_stall;
      s_mem_wb_stall = mem_wb_stall;
    end
    if ((mode == MODE_MULTI) && (multi_runs == 0)) begin
      errors++;
      $display("No multi-cycle op ever reached EX in the multi-cycle phase");
    end
    $display("test %0d %s: %0d errors in %0d cycles", num, name, errors - errs_before, cycles);
  endtask

  initial begin
    void'($urandom(47892));
    reset = 1'b1;
    rs1_id = '0;
    rs2_id = '0;
    rs1_used_id = 1'b0;
    rs2_used_id = 1'b0;
    rd_id = '0;
    reg_write_id = 1'b0;
    is_load_id = 1'b0;
    is_csr_id = 1'b0;
    is_multi_id = 1'b0;
    pc_sel = PC_SEL_SEQ;
    mispredicted_ex = 1'b0;
    btb_pred_taken = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Everything is quiet right after reset with idle ID inputs
    @(negedge clk);
    exp_front_stall = 1'b0;
    exp_back_stall = 1'b0;
    exp_if_id_flush = 1'b0;
    exp_id_ex_flush = 1'b0;
    exp_fwd1 = FWD_NONE;
    exp_fwd2 = FWD_NONE;
    check_outputs();
    $display("test 1 reset state: %0d errors", errors);
    m_ex = '0;
    m_mem = '0;
    m_wb = '0;
    m_cnt = 0;
    s_if_id_stall = 1'b0;
    s_id_ex_stall = 1'b0;
    s_id_ex_flush = 1'b0;
    s_ex_mem_stall = 1'b0;
    s_mem_wb_stall = 1'b0;

    run_phase(2, "data hazards", MODE_DATA, DATA_CYCLES);
    run_phase(3, "multi-cycle ops", MODE_MULTI, MULTI_CYCLES);
    run_phase(4, "control hazards", MODE_CTRL, CTRL_CYCLES);
    run_phase(5, "mixed forwarding", MODE_MIX, MIX_CYCLES);

    $display("tests 5, multi-cycle runs %0d, errors %0d", multi_runs, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- sim.f
rv_pipe_pkg.sv
rv_stage_if.sv
rv_hazard.sv
rv_forward.sv
rv_stage_regs.sv
rv_pipe_ctl.sv
tb_rv_pipe_ctl.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rv_pipe_ctl
FWD ?= 1
FWD_REGFILE ?= 0
MEM_TYPE ?= 0
MULTI_LATENCY ?= 3
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) \
	  -GFWD=$(FWD) -GFWD_REGFILE=$(FWD_REGFILE) -GMEM_TYPE=$(MEM_TYPE) \
	  -GMULTI_LATENCY=$(MULTI_LATENCY) --Mdir $(OBJ_DIR) -o sim_bin
	./$(OBJ_DIR)/sim_bin | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
